//--- verilog/vlane_defines.svh
// Sizing macros for the vector lane array, included by the package, the RTL and the testbench
`ifndef VLANE_DEFINES_SVH
`define VLANE_DEFINES_SVH

////////////////////////////////////////////////////////////
// Array geometry

`define VLANE_NUM       4   // Lanes in the ring
`define ELEMS_PER_LANE  4   // Slots per vector in one lane
`define VREG_NUM        8   // Architectural vector registers

// Words held by one lane slice
`define VRF_DEPTH       (`VREG_NUM * `ELEMS_PER_LANE)

////////////////////////////////////////////////////////////
// Datapath and flow control

`define DATA_W          32  // Element width
`define STORE_CREDITS   4   // Sink credits held after reset

`endif

//--- verilog/vlane_pkg.sv
// Shared types of the vector lane array; modules take them with a wildcard import
`include "vlane_defines.svh"

package vlane_pkg;

    ////////////////////////////////////////////////////////////
    // Opcodes

    typedef enum logic [3:0] {
        VOP_ADD     = 4'h0,
        VOP_SUB     = 4'h1,
        VOP_AND     = 4'h2,
        VOP_OR      = 4'h3,
        VOP_XOR     = 4'h4,
        VOP_ADDX    = 4'h5,  // Vector plus scalar
        VOP_SLIDEUP = 4'h6,
        VOP_SLIDEDN = 4'h7,
        VOP_LOAD    = 4'h8,
        VOP_STORE   = 4'h9
    } vop_e;

    ////////////////////////////////////////////////////////////
    // Data and addressing

    typedef logic [`DATA_W-1:0] word_t;

    typedef logic [$clog2(`VREG_NUM)-1:0] vreg_t;

    typedef logic [$clog2(`ELEMS_PER_LANE)-1:0] slot_t;

    // Lane slice address, register on top of slot
    typedef struct packed {
        vreg_t vreg;
        slot_t slot;
    } vrf_addr_t;

endpackage

//--- verilog/vlane_vrf.sv
// Register file slice of one lane; two registered read ports and one write port
`timescale 1ns/10ps
`include "vlane_defines.svh"

module vlane_vrf import vlane_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  vrf_addr_t raddr1_i,
    input  vrf_addr_t raddr2_i,
    input  logic      ren_i,
    input  vrf_addr_t waddr_i,
    input  logic      wen_i,
    input  word_t     wdata_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o
);

    word_t mem_q [`VRF_DEPTH];

    always_ff @(posedge clk_i) begin
        if (wen_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // Both ports share one enable
    always_ff @(posedge clk_i) begin
        if (ren_i) begin
            rdata1_o <= mem_q[raddr1_i];
            rdata2_o <= mem_q[raddr2_i];
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks

    // Write-back trails the walk, never hits the slot being read
    a_no_rw_collide: assert property (@(posedge clk_i) disable iff (rst_i)
        (ren_i && wen_i) |-> (raddr1_i != waddr_i) && (raddr2_i != waddr_i));

endmodule

//--- verilog/vlane_lane.sv
// One vector lane; register file slice, element ALU and write data select
`timescale 1ns/10ps
`include "vlane_defines.svh"

module vlane_lane import vlane_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  vrf_addr_t raddr1_i,
    input  vrf_addr_t raddr2_i,
    input  logic      ren_i,
    input  vrf_addr_t waddr_i,
    input  logic      wen_i,
    input  vop_e      op_i,
    input  word_t     scalar_i,
    input  word_t     load_word_i,
    input  word_t     slide_word_i,
    output word_t     rdata1_o
);

    word_t rdata2;
    word_t alu_res;
    word_t wdata;

    vlane_vrf u_vrf (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .raddr1_i (raddr1_i),
        .raddr2_i (raddr2_i),
        .ren_i    (ren_i),
        .waddr_i  (waddr_i),
        .wen_i    (wen_i),
        .wdata_i  (wdata),
        .rdata1_o (rdata1_o),
        .rdata2_o (rdata2)
    );

    ////////////////////////////////////////////////////////////
    // Element ALU

    always_comb begin
        case (op_i)
            VOP_ADD:  alu_res = rdata1_o + rdata2;
            VOP_SUB:  alu_res = rdata1_o - rdata2;
            VOP_AND:  alu_res = rdata1_o & rdata2;
            VOP_OR:   alu_res = rdata1_o | rdata2;
            VOP_XOR:  alu_res = rdata1_o ^ rdata2;
            VOP_ADDX: alu_res = rdata1_o + scalar_i;
            default:  alu_res = '0;
        endcase
    end

    // Write data source
    always_comb begin
        case (op_i)
            VOP_LOAD:    wdata = load_word_i;
            VOP_SLIDEUP,
            VOP_SLIDEDN: wdata = slide_word_i;  // From the ring
            default:     wdata = alu_res;
        endcase
    end

endmodule

//--- verilog/vlane_slide_net.sv
// Slide ring between lanes; carries the edge word across slots and inserts the scalar
`timescale 1ns/10ps
`include "vlane_defines.svh"

module vlane_slide_net import vlane_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  word_t [`VLANE_NUM-1:0]  lane_word_i,
    input  vop_e                    op_i,
    input  word_t                   scalar_i,
    input  logic                    step_i,
    input  logic                    first_i,
    output word_t [`VLANE_NUM-1:0]  slide_word_o
);

    localparam int N = `VLANE_NUM;

    word_t carry_q;  // Edge lane word of the previous slot
    logic  down;

    assign down = (op_i == VOP_SLIDEDN);

    ////////////////////////////////////////////////////////////
    // Ring

    always_comb begin
        if (down) begin
            for (int i = 0; i < N - 1; i++) begin
                slide_word_o[i] = lane_word_i[i + 1];
            end
            slide_word_o[N - 1] = first_i ? scalar_i : carry_q;
        end else begin
            for (int i = 1; i < N; i++) begin
                slide_word_o[i] = lane_word_i[i - 1];
            end
            slide_word_o[0] = first_i ? scalar_i : carry_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (step_i) begin
            carry_q <= down ? lane_word_i[0] : lane_word_i[N - 1];
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks

    // Slide steps run back to back, so the carry is always fresh
    a_carry_fresh: assert property (@(posedge clk_i) disable iff (rst_i)
        (step_i && !first_i) |-> $past(step_i));

endmodule

//--- verilog/vlane_seq.sv
// Instruction sequencer; walks the slots and drives addresses, enables and credits for all lanes
`timescale 1ns/10ps
`include "vlane_defines.svh"

module vlane_seq import vlane_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      start_i,
    input  vop_e      op_i,
    input  vreg_t     vd_i,
    input  vreg_t     vs1_i,
    input  vreg_t     vs2_i,
    input  word_t     scalar_i,
    input  logic      load_valid_i,
    input  logic      store_credit_i,
    output logic      ready_o,
    output logic      load_credit_o,
    output logic      store_valid_o,
    output vrf_addr_t raddr1_o,
    output vrf_addr_t raddr2_o,
    output logic      ren_o,
    output vrf_addr_t waddr_o,
    output logic      wen_o,
    output vop_e      op_o,
    output word_t     scalar_o,
    output logic      slide_step_o,
    output logic      slide_first_o
);

    localparam int    CNT_W     = $clog2(`ELEMS_PER_LANE + 1);
    localparam int    CRED_W    = $clog2(`STORE_CREDITS + 1);
    localparam slot_t LAST_SLOT = slot_t'(`ELEMS_PER_LANE - 1);

    typedef enum logic [1:0] {ST_IDLE, ST_WALK, ST_DRAIN, ST_LOAD} state_e;

    state_e            st_q;
    vop_e              op_q;
    vreg_t             vd_q, vs1_q, vs2_q;
    word_t             scalar_q;
    slot_t             slot_q;
    logic              first_q;
    logic [CRED_W-1:0] cred_q;
    logic [CNT_W-1:0]  lc_left_q;
    logic [CNT_W-1:0]  beat_q;
    logic              ren_q, v2_q;
    slot_t             r_slot_q, w_slot_q;
    logic              r_first_q, w_first_q;
    logic              r_last_q, w_last_q;

    logic accept, is_store, is_slide, descend, walk_last, issue, spend;
    logic load_done, walk_done;

    assign ready_o   = (st_q == ST_IDLE);
    assign accept    = start_i && ready_o;
    assign is_store  = (op_q == VOP_STORE);
    assign is_slide  = (op_q == VOP_SLIDEUP) || (op_q == VOP_SLIDEDN);
    assign descend   = (op_q == VOP_SLIDEDN);
    assign walk_last = descend ? (slot_q == '0) : (slot_q == LAST_SLOT);
    assign issue     = (st_q == ST_WALK) && (!is_store || cred_q != '0); // Stores wait on credit
    assign spend     = issue && is_store;
    assign load_done = (st_q == ST_LOAD) && load_valid_i
                       && (beat_q == CNT_W'(`ELEMS_PER_LANE - 1));
    assign walk_done = v2_q && w_last_q;

    ////////////////////////////////////////////////////////////
    // Control FSM

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            st_q <= ST_IDLE;
            op_q <= VOP_ADD;
        end else begin
            case (st_q)
                ST_IDLE: if (accept) begin
                    st_q <= (op_i == VOP_LOAD) ? ST_LOAD : ST_WALK;
                    op_q <= op_i;
                end
                ST_WALK:  if (issue && walk_last) st_q <= ST_DRAIN;
                ST_DRAIN: if (walk_done) st_q <= ST_IDLE;
                ST_LOAD:  if (load_done) st_q <= ST_IDLE;
                default:  st_q <= ST_IDLE;
            endcase
        end
    end

    // Counters and pipeline valids
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cred_q    <= CRED_W'(`STORE_CREDITS);
            lc_left_q <= '0;
            beat_q    <= '0;
            ren_q     <= 1'b0;
            v2_q      <= 1'b0;
        end else begin
            cred_q <= cred_q - CRED_W'(spend) + CRED_W'(store_credit_i);
            if (accept && op_i == VOP_LOAD) begin
                lc_left_q <= CNT_W'(`ELEMS_PER_LANE);
                beat_q    <= '0;
            end else begin
                if (lc_left_q != '0) lc_left_q <= lc_left_q - 1'b1;
                if (st_q == ST_LOAD && load_valid_i) beat_q <= beat_q + 1'b1;
            end
            ren_q <= issue;
            v2_q  <= ren_q;  // Read data valid in the lanes
        end
    end

    ////////////////////////////////////////////////////////////
    // Instruction latch and slot walk

    always_ff @(posedge clk_i) begin
        if (accept) begin
            vd_q     <= vd_i;
            vs1_q    <= vs1_i;
            vs2_q    <= vs2_i;
            scalar_q <= scalar_i;
            slot_q   <= (op_i == VOP_SLIDEDN) ? LAST_SLOT : '0;
            first_q  <= 1'b1;
        end else if (issue) begin
            slot_q  <= descend ? slot_q - 1'b1 : slot_q + 1'b1;
            first_q <= 1'b0;
        end
        r_slot_q  <= slot_q;
        r_first_q <= first_q;
        r_last_q  <= walk_last;
        w_slot_q  <= r_slot_q;   // Write-back copy
        w_first_q <= r_first_q;
        w_last_q  <= r_last_q;
    end

    // Stores and slides take their data from vs1
    assign raddr1_o = '{vreg: vs1_q, slot: r_slot_q};
    assign raddr2_o = '{vreg: vs2_q, slot: r_slot_q};
    assign ren_o    = ren_q;

    assign waddr_o = '{vreg: vd_q,
                       slot: (st_q == ST_LOAD) ? slot_t'(beat_q) : w_slot_q};
    assign wen_o   = (st_q == ST_LOAD) ? load_valid_i : (v2_q && !is_store);

    assign load_credit_o = (lc_left_q != '0);
    assign store_valid_o = v2_q && is_store;
    assign slide_step_o  = v2_q && is_slide;
    assign slide_first_o = slide_step_o && w_first_q;
    assign op_o          = op_q;
    assign scalar_o      = scalar_q;

    ////////////////////////////////////////////////////////////
    // Checks

    a_store_cred_max: assert property (@(posedge clk_i) disable iff (rst_i)
        cred_q <= CRED_W'(`STORE_CREDITS));

    // A beat needs a credit that the source has already seen
    a_load_beat_owed: assert property (@(posedge clk_i) disable iff (rst_i)
        load_valid_i |-> (st_q == ST_LOAD)
                         && (beat_q < CNT_W'(`ELEMS_PER_LANE) - lc_left_q));

endmodule

//--- verilog/vlane_array.sv
// Top level of the vector lane array; sequencer, lanes and slide ring
`timescale 1ns/10ps
`include "vlane_defines.svh"

module vlane_array import vlane_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_i,

    // Issue
    input  logic                    start_i,
    output logic                    ready_o,
    input  vop_e                    op_i,
    input  vreg_t                   vd_i,
    input  vreg_t                   vs1_i,
    input  vreg_t                   vs2_i,
    input  word_t                   scalar_i,

    // Load source
    output logic                    load_credit_o,
    input  logic                    load_valid_i,
    input  word_t [`VLANE_NUM-1:0]  load_data_i,

    // Store sink
    output logic                    store_valid_o,
    output word_t [`VLANE_NUM-1:0]  store_data_o,
    input  logic                    store_credit_i
);

    ////////////////////////////////////////////////////////////
    // Sequencer to lanes

    vrf_addr_t raddr1, raddr2, waddr;
    logic      ren, wen;
    vop_e      lane_op;
    word_t     lane_scalar;
    logic      slide_step, slide_first;

    word_t [`VLANE_NUM-1:0] slide_word;

    vlane_seq u_seq (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .start_i        (start_i),
        .op_i           (op_i),
        .vd_i           (vd_i),
        .vs1_i          (vs1_i),
        .vs2_i          (vs2_i),
        .scalar_i       (scalar_i),
        .load_valid_i   (load_valid_i),
        .store_credit_i (store_credit_i),
        .ready_o        (ready_o),
        .load_credit_o  (load_credit_o),
        .store_valid_o  (store_valid_o),
        .raddr1_o       (raddr1),
        .raddr2_o       (raddr2),
        .ren_o          (ren),
        .waddr_o        (waddr),
        .wen_o          (wen),
        .op_o           (lane_op),
        .scalar_o       (lane_scalar),
        .slide_step_o   (slide_step),
        .slide_first_o  (slide_first)
    );

    for (genvar i = 0; i < `VLANE_NUM; i++) begin : g_lane
        vlane_lane u_lane (
            .clk_i        (clk_i),
            .rst_i        (rst_i),
            .raddr1_i     (raddr1),
            .raddr2_i     (raddr2),
            .ren_i        (ren),
            .waddr_i      (waddr),
            .wen_i        (wen),
            .op_i         (lane_op),
            .scalar_i     (lane_scalar),
            .load_word_i  (load_data_i[i]),
            .slide_word_i (slide_word[i]),
            .rdata1_o     (store_data_o[i])  // Also feeds the ring
        );
    end

    vlane_slide_net u_slide (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .lane_word_i  (store_data_o),
        .op_i         (lane_op),
        .scalar_i     (lane_scalar),
        .step_i       (slide_step),
        .first_i      (slide_first),
        .slide_word_o (slide_word)
    );

endmodule

//--- test/vlane_tb_ref.svh
// Reference model of the vector registers and expected results per opcode, included by vlane_tb
`ifndef VLANE_TB_REF_SVH
`define VLANE_TB_REF_SVH

localparam int VLEN = `VLANE_NUM * `ELEMS_PER_LANE;  // Elements per vector

word_t model_q [`VREG_NUM][VLEN];

// One element of an elementwise op
function automatic word_t elem_result(vop_e op, word_t a, word_t b, word_t scalar);
    case (op)
        VOP_ADD:  return a + b;
        VOP_SUB:  return a - b;
        VOP_AND:  return a & b;
        VOP_OR:   return a | b;
        VOP_XOR:  return a ^ b;
        VOP_ADDX: return a + scalar;
        default:  return '0;
    endcase
endfunction

// Neighbor element of the source, scalar at the open end
function automatic word_t slide_result(vop_e op, vreg_t src, int e, word_t scalar);
    if (op == VOP_SLIDEUP) begin
        if (e == 0) return scalar;
        return model_q[src][e - 1];
    end
    if (e == VLEN - 1) return scalar;
    return model_q[src][e + 1];
endfunction

// Full vector result into the model, safe when vd is also a source
function automatic void model_apply(vop_e op, vreg_t vd, vreg_t vs1, vreg_t vs2, word_t scalar);
    word_t res [VLEN];
    for (int e = 0; e < VLEN; e++) begin
        if (op == VOP_SLIDEUP || op == VOP_SLIDEDN) res[e] = slide_result(op, vs1, e, scalar);
        else res[e] = elem_result(op, model_q[vs1][e], model_q[vs2][e], scalar);
    end
    for (int e = 0; e < VLEN; e++) model_q[vd][e] = res[e];
endfunction

`endif

//--- test/vlane_tb.sv
// Testbench for the vector lane array; loads, arithmetic, slides and stores checked against a model
`timescale 1ns/10ps
`include "vlane_defines.svh"

module vlane_tb import vlane_pkg::*; ();

    `include "vlane_tb_ref.svh"

    // 8 loads + 8 stores, 6 ops + 6 stores, 2 slides + 2 stores, 3 slow stores
    localparam int NUM_INSTR   = 35;
    localparam int CYCLE_LIMIT = 60 * NUM_INSTR;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   start;
    logic                   ready;
    vop_e                   op;
    vreg_t                  vd, vs1, vs2;
    word_t                  scalar;
    logic                   load_credit;
    logic                   load_valid = 1'b0;
    word_t [`VLANE_NUM-1:0] load_data = '0;
    logic                   store_valid;
    word_t [`VLANE_NUM-1:0] store_data;
    logic                   store_credit = 1'b0;

    logic [31:0] data_rng = 32'h8155;
    logic [31:0] src_rng = 32'h8155;
    logic [31:0] snk_rng = 32'h8155;
    word_t       load_q[$];
    word_t       exp_q[$];
    string       test_name = "none";
    logic        slow = 1'b0;  // Sink holds credits longer
    int          src_cred = 0, owed = 0, beats_seen = 0, credits_back = 0;
    int          cycle_cnt = 0;

    always #2 clk = ~clk;

    vlane_array u_dut (
        .clk_i          (clk),
        .rst_i          (rst),
        .start_i        (start),
        .ready_o        (ready),
        .op_i           (op),
        .vd_i           (vd),
        .vs1_i          (vs1),
        .vs2_i          (vs2),
        .scalar_i       (scalar),
        .load_credit_o  (load_credit),
        .load_valid_i   (load_valid),
        .load_data_i    (load_data),
        .store_valid_o  (store_valid),
        .store_data_o   (store_data),
        .store_credit_i (store_credit)
    );

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) fail_now($sformatf("error %s: expected %h, actual %h", name, exp, act));
    endtask

    ////////////////////////////////////////////////////////////
    // Load source and store sink

    always @(negedge clk) begin
        load_valid = 1'b0;
        if (src_cred > 0 && src_rng[17:16] != 2'b00) begin  // Random hold-off
            if (load_q.size() < `VLANE_NUM) fail_now("load credit granted with no load data queued");
            load_valid = 1'b1;
            for (int i = 0; i < `VLANE_NUM; i++) load_data[i] = load_q.pop_front();
            src_cred--;
        end
        src_rng = lcg(src_rng);
        if (load_credit) src_cred++;  // Usable from the next cycle on
    end

    // Compare process; also returns store credits
    always @(negedge clk) begin
        store_credit = 1'b0;
        snk_rng = lcg(snk_rng);
        if (store_valid) begin
            beats_seen++;
            if (beats_seen > `STORE_CREDITS + credits_back)
                fail_now("store beat arrived without a credit from the sink");
            if (exp_q.size() < `VLANE_NUM) fail_now("store beat arrived with no store pending");
            for (int i = 0; i < `VLANE_NUM; i++)
                check($sformatf("%s beat %0d lane %0d", test_name,
                                (beats_seen - 1) % `ELEMS_PER_LANE, i),
                      exp_q.pop_front(), store_data[i]);
            owed++;
        end
        if (owed > 0 && (slow ? snk_rng[20:18] == 3'd0 : snk_rng[19])) begin
            store_credit = 1'b1;
            owed--;
            credits_back++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT)
            fail_now($sformatf("run did not end within %0d cycles", CYCLE_LIMIT));
    end

    ////////////////////////////////////////////////////////////
    // Instruction tasks

    // Holds start until accepted, then counts cycles until ready returns
    task automatic run_instr(input vop_e o, input vreg_t d, input vreg_t s1, input vreg_t s2,
                             input word_t x, output int lat);
        @(negedge clk);
        op     = o;
        vd     = d;
        vs1    = s1;
        vs2    = s2;
        scalar = x;
        start  = 1'b1;
        while (!ready) @(negedge clk);
        @(negedge clk);
        start = 1'b0;
        lat   = 0;
        while (!ready) begin
            @(negedge clk);
            lat++;
        end
    endtask

    task automatic load_vec(input vreg_t r);
        int lat;
        for (int e = 0; e < VLEN; e++) begin
            data_rng = lcg(data_rng);
            model_q[r][e] = data_rng;
            load_q.push_back(data_rng);  // Slot order with lane 0 first
        end
        run_instr(VOP_LOAD, r, '0, '0, '0, lat);
    endtask

    task automatic store_vec(input vreg_t r, input string name);
        int lat;
        test_name = name;
        for (int e = 0; e < VLEN; e++) exp_q.push_back(model_q[r][e]);
        run_instr(VOP_STORE, '0, r, '0, '0, lat);
        check({name, " beats missing"}, 0, exp_q.size());
    endtask

    task automatic arith(input vop_e o, input vreg_t d, input vreg_t s1, input vreg_t s2);
        int lat;
        data_rng = lcg(data_rng);
        model_apply(o, d, s1, s2, data_rng);
        run_instr(o, d, s1, s2, data_rng, lat);
        check({o.name(), " latency"}, `ELEMS_PER_LANE + 2, lat);
        store_vec(d, o.name());
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        start  = 1'b0;
        op     = VOP_ADD;
        vd     = '0;
        vs1    = '0;
        vs2    = '0;
        scalar = '0;
        rst    = 1'b1;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check("reset ready", 1, ready);
        check("reset store_valid", 0, store_valid);
        check("reset load_credit", 0, load_credit);

        for (int r = 0; r < `VREG_NUM; r++) load_vec(r);
        for (int r = 0; r < `VREG_NUM; r++) store_vec(r, $sformatf("load store v%0d", r));

        arith(VOP_ADD, 0, 1, 2);
        arith(VOP_SUB, 3, 1, 2);
        arith(VOP_AND, 5, 6, 7);
        arith(VOP_OR, 6, 3, 7);
        arith(VOP_XOR, 4, 4, 5);  // In place
        arith(VOP_ADDX, 7, 2, 0);
        arith(VOP_SLIDEUP, 1, 0, 0);
        arith(VOP_SLIDEDN, 2, 3, 0);

        slow = 1'b1;
        store_vec(1, "slow credit v1");
        store_vec(2, "slow credit v2");
        store_vec(4, "slow credit v4");
        slow = 1'b0;

        check("load words left", 0, load_q.size());
        $display("All checks passed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+verilog
+incdir+test
verilog/vlane_pkg.sv
verilog/vlane_vrf.sv
verilog/vlane_lane.sv
verilog/vlane_slide_net.sv
verilog/vlane_seq.sv
verilog/vlane_array.sv
test/vlane_tb.sv

//--- Bender.yml
package:
  name: vlane_array

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/vlane_pkg.sv
      - verilog/vlane_vrf.sv
      - verilog/vlane_lane.sv
      - verilog/vlane_slide_net.sv
      - verilog/vlane_seq.sv
      - verilog/vlane_array.sv
  - target: test
    include_dirs:
      - verilog
      - test
    files:
      - test/vlane_tb.sv
